// ==== project.f ====
design/afu_pkg.sv
design/local_mem_bank.sv
design/mmio_bridge.sv
design/csr_block.sv
design/dma_copy_engine.sv
design/afu_top.sv
dv/afu_assertions.sv
dv/tb_afu.sv

// ==== Makefile ====
# Verilator build and run of the accelerator testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_afu
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_afu.sv ====
// directed testbench for the memory-copy accelerator
//   clock, reset, Galois LFSR value source
//   MMIO request tasks, response monitor, DMA job helper
//   ID, scratch, fill/copy/sum, busy-start and length edge tests, watchdog
module tb_afu;
	import afu_pkg::*;

	localparam int MEM_DEPTH   = 1024;
	localparam int RSP_TAGS    = 2;                       // small, so reads back up on rd_full
	localparam int WORD_CYCLES = 8;                       // worst case cycles per word
	localparam int JOB_WORDS   = 3 * 64 + 4 * MEM_DEPTH;  // words over all DMA jobs
	localparam int MMIO_OPS    = 80;
	localparam int EST_CYCLES  = JOB_WORDS * WORD_CYCLES + MMIO_OPS * 12;
	localparam int MARGIN      = 4;

	logic        Clk_400;
	logic        rst_n;
	mmio_req_t   mmio_req;
	logic        rd_full;
	mmio_rsp_t   mmio_rsp;
	logic        dma_busy;

	logic [31:0] lfsr = 32'h2e33_f56f;
	logic [8:0]  next_tag;
	logic [8:0]  tag_fifo[$];                             // tags of reads in flight
	mmio_rsp_t   rsp_fifo[$];
	logic [7:0]  done_exp;                                // expected done count

	afu_top #(.MEM_DEPTH(MEM_DEPTH), .RSP_TAGS(RSP_TAGS)) u_afu_top (
		.Clk_400, .rst_n, .mmio_req, .rd_full, .mmio_rsp, .dma_busy
	);

	initial begin
		Clk_400 = 1'b0;
		forever #4 Clk_400 = ~Clk_400;
	end

	// responses sampled away from the active edge
	always @(negedge Clk_400)
		if (rst_n && mmio_rsp.valid)
			rsp_fifo.push_back(mmio_rsp);

	// ************************************************************************
	// helpers
	// ************************************************************************
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// n*s + n(n-1)/2, modulo 2^64
	function automatic logic [63:0] sum_exp(input int n, input logic [63:0] s);
		logic [63:0] nn;
		nn = 64'(n);
		return nn * s + (nn * (nn - 64'd1)) / 64'd2;
	endfunction

	function automatic logic [63:0] status_exp(input logic busy);
		return {48'd0, done_exp, 7'd0, busy};
	endfunction

	task automatic fail_stop();
		$display("test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic expect_eq(input string tname, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp) else begin
			$display("ERR %s: expected %h, actual %h", tname, exp, got);
			fail_stop();
		end
	endtask

	// called at a negedge, returns at the next one
	task automatic send_req(input logic wr, input logic [15:0] addr, input logic [63:0] data);
		while (!wr && rd_full)
			@(negedge Clk_400);                           // host holds reads while full
		mmio_req = '{valid: 1'b1, write: wr, tag: next_tag, addr: addr, data: data};
		if (!wr)
			tag_fifo.push_back(next_tag);
		next_tag = next_tag + 9'd1;
		@(negedge Clk_400);
		mmio_req.valid = 1'b0;                            // next send may raise it again
	endtask

	task automatic take_rsp(input string tname, input logic [63:0] exp);
		mmio_rsp_t  r;
		logic [8:0] t;
		for (int c = 0; rsp_fifo.size() == 0; c++) begin
			if (c == 40) begin
				$display("no read response within 40 cycles in %s", tname);
				fail_stop();
			end
			@(negedge Clk_400);
		end
		r = rsp_fifo.pop_front();
		t = tag_fifo.pop_front();
		expect_eq({tname, " tag"}, 64'(t), 64'(r.tag));
		expect_eq(tname, exp, r.data);
	endtask

	task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
		send_req(1'b1, addr, data);
	endtask

	task automatic mmio_read(input string tname, input logic [15:0] addr, input logic [63:0] exp);
		send_req(1'b0, addr, 64'd0);
		take_rsp(tname, exp);
	endtask

	task automatic wait_busy(input logic level, input int limit);
		for (int c = 0; dma_busy !== level; c++) begin
			if (c == limit) begin
				$display("dma_busy did not go to %b within %0d cycles", level, limit);
				fail_stop();
			end
			@(negedge Clk_400);
		end
	endtask

	task automatic run_job(input dma_op_t op, input int n, input logic [63:0] s);
		mmio_write(REG_DMA_LEN, 64'(n));
		mmio_write(REG_DMA_SEED, s);
		mmio_write(REG_DMA_CTRL, {62'd0, op});
		wait_busy(1'b1, 20);                              // zero length still pulses busy
		wait_busy(1'b0, n * WORD_CYCLES + 20);
		done_exp++;
	endtask

	// ************************************************************************
	// tests
	// ************************************************************************
	task automatic test_id();
		mmio_read("id_low", REG_AFU_ID_L, AFU_ID[63:0]);
		mmio_read("id_high", REG_AFU_ID_H, AFU_ID[127:64]);
		mmio_write(16'h0048, rand_bits(64));              // unmapped, dropped
		mmio_read("unmapped_0048", 16'h0048, 64'd0);
		mmio_read("unmapped_0200", 16'h0200, 64'd0);
	endtask

	task automatic test_scratch();
		logic [63:0] v;
		logic [63:0] s;
		v = rand_bits(64);
		s = rand_bits(64);
		mmio_write(REG_SCRATCH, v);
		mmio_read("scratch_single", REG_SCRATCH, v);
		v = rand_bits(64);
		mmio_write(REG_SCRATCH, v);
		mmio_write(REG_DMA_SEED, s);
		// four reads back to back, responses collected afterwards
		send_req(1'b0, REG_SCRATCH, 64'd0);
		send_req(1'b0, REG_DMA_SEED, 64'd0);
		expect_eq("burst_rd_full", 64'd1, 64'(rd_full));  // both tags still pending
		send_req(1'b0, REG_AFU_ID_L, 64'd0);              // held until a tag frees
		send_req(1'b0, REG_SCRATCH, 64'd0);
		take_rsp("burst_scratch", v);
		take_rsp("burst_seed", s);
		take_rsp("burst_id_low", AFU_ID[63:0]);
		take_rsp("burst_scratch_again", v);
		expect_eq("burst_rd_drained", 64'd0, 64'(rd_full));
	endtask

	task automatic test_fill_copy_sum(input string tname, input int n);
		logic [63:0] s;
		s = rand_bits(64);
		run_job(DMA_FILL, n, s);
		mmio_read({tname, " fill status"}, REG_DMA_STATUS, status_exp(1'b0));
		mmio_read({tname, " fill result"}, REG_DMA_RESULT, 64'd0);
		run_job(DMA_COPY, n, 64'd0);
		mmio_read({tname, " copy status"}, REG_DMA_STATUS, status_exp(1'b0));
		run_job(DMA_SUM, n, 64'd0);
		mmio_read({tname, " sum status"}, REG_DMA_STATUS, status_exp(1'b0));
		mmio_read({tname, " sum result"}, REG_DMA_RESULT, sum_exp(n, s));
	endtask

	task automatic test_start_while_busy();
		mmio_write(REG_DMA_LEN, 64'(MEM_DEPTH));
		mmio_write(REG_DMA_SEED, rand_bits(64));
		mmio_write(REG_DMA_CTRL, {62'd0, DMA_FILL});
		wait_busy(1'b1, 20);
		mmio_read("busy_status", REG_DMA_STATUS, status_exp(1'b1));
		mmio_write(REG_DMA_CTRL, {62'd0, DMA_SUM});       // must be dropped
		wait_busy(1'b0, MEM_DEPTH * WORD_CYCLES + 20);
		done_exp++;
		repeat (10) @(negedge Clk_400);
		expect_eq("busy_stays_low", 64'd0, 64'(dma_busy));
		mmio_read("one_done_only", REG_DMA_STATUS, status_exp(1'b0));
	endtask

	task automatic test_len_edges();
		test_fill_copy_sum("full_depth", MEM_DEPTH);
		// result register now holds a nonzero sum
		run_job(DMA_SUM, 0, 64'd0);
		mmio_read("zero_len_status", REG_DMA_STATUS, status_exp(1'b0));
		mmio_read("zero_len_result", REG_DMA_RESULT, 64'd0);
	endtask

	// ************************************************************************
	// main sequence and watchdog
	// ************************************************************************
	initial begin
		mmio_req = '0;
		rst_n    = 1'b0;
		next_tag = '0;
		done_exp = '0;
		repeat (8) @(negedge Clk_400);
		rst_n = 1'b1;
		@(negedge Clk_400);
		test_id();
		test_scratch();
		test_fill_copy_sum("fill_copy_sum", int'(rand_bits(6)) + 1);
		test_start_while_busy();
		test_len_edges();
		$display("test passed");
		$finish;
	end

	initial begin
		repeat (EST_CYCLES * MARGIN) @(posedge Clk_400);
		$display("watchdog expired after %0d cycles", EST_CYCLES * MARGIN);
		fail_stop();
	end

endmodule

// ==== dv/afu_assertions.sv ====
// protocol checks on the accelerator top level
//   no read response while the tag queue is full
//   bank strobes held under waitrequest, never read and write together
//   busy drops only after the done pulse
module afu_assertions (
	input logic               Clk_400,
	input logic               rst_n,
	input logic               rd_full,
	input afu_pkg::mmio_rsp_t mmio_rsp,
	input afu_pkg::mem_req_t  mem_a,
	input afu_pkg::mem_req_t  mem_b,
	input logic               a_wait,
	input logic               b_wait,
	input logic               dma_busy,
	input logic               done
);

	rsp_not_full: assert property (@(posedge Clk_400) disable iff (!rst_n)
		rd_full |-> !mmio_rsp.valid)
		else $error("read response while the tag queue is full");

	// stalled strobe keeps address, data and direction
	a_hold: assert property (@(posedge Clk_400) disable iff (!rst_n)
		(mem_a.read || mem_a.write) && a_wait |=> $stable(mem_a))
		else $error("bank A strobe changed under waitrequest");

	b_hold: assert property (@(posedge Clk_400) disable iff (!rst_n)
		(mem_b.read || mem_b.write) && b_wait |=> $stable(mem_b))
		else $error("bank B strobe changed under waitrequest");

	a_one_dir: assert property (@(posedge Clk_400) disable iff (!rst_n)
		!(mem_a.read && mem_a.write))
		else $error("bank A read and write strobes both high");

	b_one_dir: assert property (@(posedge Clk_400) disable iff (!rst_n)
		!(mem_b.read && mem_b.write))
		else $error("bank B read and write strobes both high");

	busy_after_done: assert property (@(posedge Clk_400) disable iff (!rst_n)
		$fell(dma_busy) |-> $past(done))
		else $error("dma_busy fell without a done pulse");

endmodule

bind afu_top afu_assertions u_afu_assertions (
	.Clk_400, .rst_n, .rd_full, .mmio_rsp,
	.mem_a, .mem_b, .a_wait, .b_wait, .dma_busy, .done
);

// ==== design/afu_top.sv ====
// accelerator top level
//   MMIO bridge, register block, DMA engine
//   local memory banks A and B
module afu_top #(
	parameter int MEM_DEPTH = 1024,
	parameter int RSP_TAGS  = 4
) (
	input  logic               Clk_400,
	input  logic               rst_n,
	input  afu_pkg::mmio_req_t mmio_req,
	output logic               rd_full,
	output afu_pkg::mmio_rsp_t mmio_rsp,
	output logic               dma_busy
);
	import afu_pkg::*;

	// bridge <-> register block
	csr_cmd_t        cmd;
	logic            cmd_valid, cmd_ready;
	logic [63:0]     rd_data;
	logic            rd_valid, rd_ready;

	// register block <-> engine
	logic            start, done;
	dma_op_t         op;
	logic [MEM_AW:0] len;
	logic [63:0]     seed, result;

	// engine <-> banks
	mem_req_t        mem_a, mem_b;
	logic            a_wait, a_rvalid, b_wait, b_rvalid;
	logic [63:0]     a_rdata, b_rdata;

	mmio_bridge #(.RSP_TAGS(RSP_TAGS)) u_mmio_bridge (
		.Clk_400, .rst_n, .mmio_req, .rd_full,
		.cmd, .cmd_valid, .cmd_ready,
		.rd_data, .rd_valid, .rd_ready, .mmio_rsp
	);

	csr_block u_csr_block (
		.Clk_400, .rst_n, .cmd, .cmd_valid, .cmd_ready,
		.rd_data, .rd_valid, .rd_ready,
		.start, .op, .len, .seed, .busy(dma_busy), .done, .result
	);

	dma_copy_engine u_dma_copy_engine (
		.Clk_400, .rst_n, .start, .op, .len, .seed,
		.busy(dma_busy), .done, .result,
		.mem_a, .a_wait, .a_rdata, .a_rvalid,
		.mem_b, .b_wait, .b_rdata, .b_rvalid
	);

	local_mem_bank #(.MEM_DEPTH(MEM_DEPTH)) u_bank_a (
		.Clk_400, .rst_n, .req(mem_a),
		.waitrequest(a_wait), .readdata(a_rdata), .readdatavalid(a_rvalid)
	);

	local_mem_bank #(.MEM_DEPTH(MEM_DEPTH)) u_bank_b (
		.Clk_400, .rst_n, .req(mem_b),
		.waitrequest(b_wait), .readdata(b_rdata), .readdatavalid(b_rvalid)
	);

endmodule

// ==== design/dma_copy_engine.sv ====
// DMA engine over the two local memory banks
//   fill: bank A[i] = seed + i
//   copy: bank B[i] = bank A[i]
//   sum:  result = sum of bank B[i], modulo 2^64
//   one word at a time, busy level and done pulse
module dma_copy_engine (
	input  logic                     Clk_400,
	input  logic                     rst_n,
	input  logic                     start,
	input  afu_pkg::dma_op_t         op,
	input  logic [afu_pkg::MEM_AW:0] len,
	input  logic [63:0]              seed,
	output logic                     busy,
	output logic                     done,
	output logic [63:0]              result,
	output afu_pkg::mem_req_t        mem_a,
	input  logic                     a_wait,
	input  logic [63:0]              a_rdata,
	input  logic                     a_rvalid,
	output afu_pkg::mem_req_t        mem_b,
	input  logic                     b_wait,
	input  logic [63:0]              b_rdata,
	input  logic                     b_rvalid
);
	import afu_pkg::*;

	dma_state_t      state;
	dma_op_t         op_q;                    // job parameters, held for the run
	logic [MEM_AW:0] len_q;
	logic [63:0]     seed_q;
	logic [MEM_AW:0] idx;                     // current word
	logic [MEM_AW:0] idx_nxt;
	logic            last;
	logic [63:0]     data_q;                  // copy word in flight
	logic [63:0]     acc;
	logic            rd_bank_a, wr_bank_a;
	logic            rd_wait, wr_wait;
	logic            rvalid_sel;
	logic [63:0]     rdata_sel;

	assign idx_nxt = idx + 1'b1;
	assign last    = (idx_nxt == len_q);

	// copy reads A, sum reads B; fill writes A, copy writes B
	assign rd_bank_a  = (op_q == DMA_COPY);
	assign wr_bank_a  = (op_q == DMA_FILL);
	assign rd_wait    = rd_bank_a ? a_wait   : b_wait;
	assign wr_wait    = wr_bank_a ? a_wait   : b_wait;
	assign rvalid_sel = rd_bank_a ? a_rvalid : b_rvalid;
	assign rdata_sel  = rd_bank_a ? a_rdata  : b_rdata;

	assign busy   = (state != DMA_IDLE);      // rises the cycle after start
	assign done   = (state == DMA_DONE);
	assign result = acc;                      // stays 0 for fill and copy

	// ************************************************************************
	// bank strobes, held by state while waitrequest is high
	// ************************************************************************
	always_comb begin
		mem_a = '0;
		mem_b = '0;
		case (state)
			DMA_RD: begin
				if (rd_bank_a) begin
					mem_a.read = 1'b1;
					mem_a.addr = idx[MEM_AW-1:0];
				end else begin
					mem_b.read = 1'b1;
					mem_b.addr = idx[MEM_AW-1:0];
				end
			end
			DMA_WR: begin
				if (wr_bank_a) begin
					mem_a.write = 1'b1;
					mem_a.addr  = idx[MEM_AW-1:0];
					mem_a.wdata = seed_q + {{(63 - MEM_AW){1'b0}}, idx};
				end else begin
					mem_b.write = 1'b1;
					mem_b.addr  = idx[MEM_AW-1:0];
					mem_b.wdata = data_q;
				end
			end
			default: ;
		endcase
	end

	// ************************************************************************
	// FSM
	// ************************************************************************
	always_ff @(posedge Clk_400) begin
		if (!rst_n) begin
			state <= DMA_IDLE;
			idx   <= '0;
			acc   <= '0;
		end else begin
			case (state)
				DMA_IDLE: if (start) begin
					idx <= '0;
					acc <= '0;
					if (len == '0)
						state <= DMA_DONE;    // empty job
					else if (op == DMA_FILL)
						state <= DMA_WR;      // no read phase
					else if (op == DMA_COPY || op == DMA_SUM)
						state <= DMA_RD;
					else
						state <= DMA_DONE;    // undefined opcode
				end
				DMA_RD: if (!rd_wait) state <= DMA_WAIT;
				DMA_WAIT: if (rvalid_sel) begin
					if (op_q == DMA_SUM) begin
						acc   <= acc + rdata_sel;
						idx   <= idx_nxt;
						state <= last ? DMA_DONE : DMA_RD;
					end else begin
						state <= DMA_WR;
					end
				end
				DMA_WR: if (!wr_wait) begin
					idx <= idx_nxt;
					if (last)
						state <= DMA_DONE;
					else
						state <= (op_q == DMA_FILL) ? DMA_WR : DMA_RD;
				end
				default: state <= DMA_IDLE;   // DMA_DONE
			endcase
		end
	end

	always_ff @(posedge Clk_400) begin
		if (state == DMA_IDLE && start) begin
			op_q   <= op;
			len_q  <= len;
			seed_q <= seed;
		end
		if (state == DMA_WAIT && rvalid_sel)
			data_q <= rdata_sel;
	end

endmodule

// ==== design/csr_block.sv ====
// accelerator register block
//   command stream decode, read data return with valid/ready
//   ID, scratch and DMA registers
//   start pulse toward the engine, done count and result capture
module csr_block (
	input  logic                     Clk_400,
	input  logic                     rst_n,
	input  afu_pkg::csr_cmd_t        cmd,
	input  logic                     cmd_valid,
	output logic                     cmd_ready,
	output logic [63:0]              rd_data,
	output logic                     rd_valid,
	input  logic                     rd_ready,
	output logic                     start,
	output afu_pkg::dma_op_t         op,
	output logic [afu_pkg::MEM_AW:0] len,
	output logic [63:0]              seed,
	input  logic                     busy,
	input  logic                     done,
	input  logic [63:0]              result
);
	import afu_pkg::*;

	logic        take;                    // command accepted this cycle
	logic        rd_take;
	logic [63:0] scratch;
	logic [7:0]  done_cnt;                // wraps
	logic [63:0] result_q;
	logic [63:0] rd_mux;

	// stall only while a read result sits untaken
	assign cmd_ready = ~(rd_valid & ~rd_ready);
	assign take      = cmd_valid & cmd_ready;
	assign rd_take   = take & ~cmd.write;

	// ************************************************************************
	// read decode
	// ************************************************************************
	always_comb begin
		case (cmd.addr)
			REG_AFU_ID_L:   rd_mux = AFU_ID[63:0];
			REG_AFU_ID_H:   rd_mux = AFU_ID[127:64];
			REG_SCRATCH:    rd_mux = scratch;
			REG_DMA_CTRL:   rd_mux = {62'd0, op};
			REG_DMA_LEN:    rd_mux = {{(63 - MEM_AW){1'b0}}, len};
			REG_DMA_SEED:   rd_mux = seed;
			REG_DMA_STATUS: rd_mux = {48'd0, done_cnt, 7'd0, busy};
			REG_DMA_RESULT: rd_mux = result_q;
			default:        rd_mux = '0;      // unmapped
		endcase
	end

	always_ff @(posedge Clk_400) begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else if (rd_take)
			rd_valid <= 1'b1;                 // old result leaves in the same cycle
		else if (rd_ready)
			rd_valid <= 1'b0;
	end

	always_ff @(posedge Clk_400)
		if (rd_take)
			rd_data <= rd_mux;

	// ************************************************************************
	// writes and job start
	// ************************************************************************
	always_ff @(posedge Clk_400) begin
		if (!rst_n) begin
			scratch <= '0;
			len     <= '0;
			seed    <= '0;
			op      <= DMA_FILL;
			start   <= 1'b0;
		end else begin
			start <= 1'b0;                    // single cycle
			if (take && cmd.write) begin
				case (cmd.addr)
					REG_SCRATCH:  scratch <= cmd.data;
					REG_DMA_LEN:  len     <= cmd.data[MEM_AW:0];
					REG_DMA_SEED: seed    <= cmd.data;
					REG_DMA_CTRL: begin
						// busy lags start by a cycle, so block on both
						if (!busy && !start) begin
							op    <= dma_op_t'(cmd.data[1:0]);
							start <= 1'b1;
						end
					end
					default: ;                // ID and unmapped ignore writes
				endcase
			end
		end
	end

	// job completion
	always_ff @(posedge Clk_400) begin
		if (!rst_n) begin
			done_cnt <= '0;
			result_q <= '0;
		end else if (done) begin
			done_cnt <= done_cnt + 8'd1;
			result_q <= result;
		end
	end

endmodule

// ==== design/mmio_bridge.sv ====
// host MMIO request bridge
//   input register stage and command queue toward the register block
//   tag queue of pending reads, rd_full flag
//   registered tagged read responses
module mmio_bridge #(
	parameter int RSP_TAGS = 4
) (
	input  logic                Clk_400,
	input  logic                rst_n,
	input  afu_pkg::mmio_req_t  mmio_req,
	output logic                rd_full,
	output afu_pkg::csr_cmd_t   cmd,
	output logic                cmd_valid,
	input  logic                cmd_ready,
	input  logic [63:0]         rd_data,
	input  logic                rd_valid,
	output logic                rd_ready,
	output afu_pkg::mmio_rsp_t  mmio_rsp
);
	import afu_pkg::*;

	localparam int TW       = (RSP_TAGS > 1) ? $clog2(RSP_TAGS) : 1;
	localparam int CQ_DEPTH = 4;              // command queue entries

	mmio_req_t       req_q;                   // input register
	csr_cmd_t        cq [CQ_DEPTH];
	logic [1:0]      cq_wp, cq_rp;
	logic [2:0]      cq_cnt;
	logic            cq_push, cq_pop;
	logic [8:0]      tag_q [RSP_TAGS];
	logic [TW-1:0]   tag_wp, tag_rp;
	logic [TW:0]     tag_cnt;
	logic            tag_push, tag_pop;

	function automatic logic [TW-1:0] tag_inc(input logic [TW-1:0] p);
		return (p == TW'(RSP_TAGS - 1)) ? '0 : p + 1'b1;
	endfunction

	// ************************************************************************
	// request register and command queue
	// ************************************************************************
	always_ff @(posedge Clk_400) begin
		if (!rst_n)
			req_q.valid <= 1'b0;
		else
			req_q <= mmio_req;
	end

	assign cq_push   = req_q.valid;
	assign cq_pop    = cmd_valid & cmd_ready;
	assign cmd_valid = (cq_cnt != 3'd0);       // cycle after the input register
	assign cmd       = cq[cq_rp];

	// the register block only stalls on an untaken read result, so the queue stays shallow
	always_ff @(posedge Clk_400)
		if (cq_push)
			cq[cq_wp] <= '{write: req_q.write, addr: req_q.addr, data: req_q.data};

	always_ff @(posedge Clk_400) begin
		if (!rst_n) begin
			cq_wp  <= '0;
			cq_rp  <= '0;
			cq_cnt <= '0;
		end else begin
			if (cq_push) cq_wp <= cq_wp + 1'b1;
			if (cq_pop)  cq_rp <= cq_rp + 1'b1;
			cq_cnt <= cq_cnt + {2'b00, cq_push} - {2'b00, cq_pop};
		end
	end

	// ************************************************************************
	// pending read tags, oldest first
	// ************************************************************************
	assign tag_push = mmio_req.valid & ~mmio_req.write; // reserve at arrival
	assign tag_pop  = rd_valid & rd_ready;
	assign rd_ready = (tag_cnt != '0);
	assign rd_full  = (tag_cnt == (TW + 1)'(RSP_TAGS));

	always_ff @(posedge Clk_400)
		if (tag_push)
			tag_q[tag_wp] <= mmio_req.tag;

	always_ff @(posedge Clk_400) begin
		if (!rst_n) begin
			tag_wp  <= '0;
			tag_rp  <= '0;
			tag_cnt <= '0;
		end else begin
			if (tag_push) tag_wp <= tag_inc(tag_wp);
			if (tag_pop)  tag_rp <= tag_inc(tag_rp);
			tag_cnt <= tag_cnt + {{TW{1'b0}}, tag_push} - {{TW{1'b0}}, tag_pop};
		end
	end

	// response register, one pulse per read
	always_ff @(posedge Clk_400) begin
		if (!rst_n) begin
			mmio_rsp.valid <= 1'b0;
		end else begin
			mmio_rsp.valid <= tag_pop;
			if (tag_pop) begin
				mmio_rsp.tag  <= tag_q[tag_rp];
				mmio_rsp.data <= rd_data;
			end
		end
	end

endmodule

// ==== design/local_mem_bank.sv ====
// local memory bank model
//   single port word array, MEM_DEPTH x 64
//   waitrequest high for one cycle after each accepted access
//   read data two cycles after the accepted read
module local_mem_bank #(
	parameter int MEM_DEPTH = 1024
) (
	input  logic              Clk_400,
	input  logic              rst_n,
	input  afu_pkg::mem_req_t req,
	output logic              waitrequest,
	output logic [63:0]       readdata,
	output logic              readdatavalid
);
	import afu_pkg::*;

	localparam int IW = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

	logic [63:0]   mem [MEM_DEPTH];          // not cleared by reset
	logic [IW-1:0] word;
	logic          accept;
	logic          gap;                      // busy cycle after an access
	logic          rv1;                      // read pipe stage 1 valid
	logic [63:0]   rd1;

	assign word        = req.addr[IW-1:0];   // upper bits unused for small banks
	assign waitrequest = gap;
	assign accept      = (req.read | req.write) & ~gap;

	// ************************************************************************
	// handshake and read pipeline control
	// ************************************************************************
	always_ff @(posedge Clk_400) begin
		if (!rst_n) begin
			gap           <= 1'b0;
			rv1           <= 1'b0;
			readdatavalid <= 1'b0;
		end else begin
			gap           <= accept;
			rv1           <= accept & req.read;
			readdatavalid <= rv1;            // 2 cycles after accept
		end
	end

	// array and data path
	always_ff @(posedge Clk_400) begin
		if (accept && req.write)
			mem[word] <= req.wdata;
		if (accept && req.read)
			rd1 <= mem[word];
		readdata <= rd1;
	end

endmodule

// ==== design/afu_pkg.sv ====
// shared definitions for the memory-copy accelerator
//   host request/response structs, command stream word, bank access struct
//   DMA opcode and engine state enums
//   register offsets and accelerator ID
package afu_pkg;

	// ************************************************************************
	// widths and constants
	// ************************************************************************
	localparam int MEM_AW = 10;                   // bank word address bits

	localparam logic [127:0] AFU_ID = 128'h7a3c_51e2_9d04_4b86_a1f0_c3d5_e6b7_2948;

	// register map, quadword aligned byte offsets
	localparam logic [15:0] REG_AFU_ID_L   = 16'h0000;
	localparam logic [15:0] REG_AFU_ID_H   = 16'h0008;
	localparam logic [15:0] REG_SCRATCH    = 16'h0080;
	localparam logic [15:0] REG_DMA_CTRL   = 16'h0100; // op in 1:0, write starts job
	localparam logic [15:0] REG_DMA_LEN    = 16'h0108;
	localparam logic [15:0] REG_DMA_SEED   = 16'h0110;
	localparam logic [15:0] REG_DMA_STATUS = 16'h0118; // busy bit 0, done count 15:8
	localparam logic [15:0] REG_DMA_RESULT = 16'h0120;

	// ************************************************************************
	// enums
	// ************************************************************************
	typedef enum logic [1:0] {
		DMA_FILL = 2'd0,                          // seed + index into bank A
		DMA_COPY = 2'd1,                          // bank A -> bank B
		DMA_SUM  = 2'd2                           // add up bank B
	} dma_op_t;

	typedef enum logic [2:0] {
		DMA_IDLE = 3'd0,
		DMA_RD   = 3'd1,                          // read strobe out
		DMA_WAIT = 3'd2,                          // waiting on readdatavalid
		DMA_WR   = 3'd3,                          // write strobe out
		DMA_DONE = 3'd4                           // one cycle, done pulse
	} dma_state_t;

	// ************************************************************************
	// structs
	// ************************************************************************
	typedef struct packed {
		logic        valid;
		logic        write;                       // 0 = read
		logic [8:0]  tag;
		logic [15:0] addr;                        // byte address
		logic [63:0] data;
	} mmio_req_t;                                 // 91 bits

	typedef struct packed {
		logic        valid;
		logic [8:0]  tag;
		logic [63:0] data;
	} mmio_rsp_t;                                 // 74 bits

	typedef struct packed {
		logic        write;
		logic [15:0] addr;
		logic [63:0] data;
	} csr_cmd_t;                                  // 81 bits

	typedef struct packed {
		logic              read;
		logic              write;
		logic [MEM_AW-1:0] addr;                  // word address
		logic [63:0]       wdata;
	} mem_req_t;

endpackage
